/* design/mips_pkg.sv */
package mips_pkg;

    // ------------------------------------------------------------------------
    // Widths and vector types
    // ------------------------------------------------------------------------
    localparam int NB_DATA        = 32;
    localparam int NB_REG_ADDRESS = 5;

    typedef logic [NB_DATA-1:0]        data_t;
    typedef logic [NB_REG_ADDRESS-1:0] reg_addr_t;

    // ------------------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------------------
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // Function field, R-type only
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam data_t INSTR_NOP  = 32'h0000_0000;
    localparam data_t INSTR_HALT = 32'hffff_ffff;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_LUI = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src_imm;
        logic    reg_dst_rd;
        logic    zero_extend;
        alu_op_e alu_op;
    } ctrl_t;

    // ------------------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------------------
    typedef struct packed {
        data_t instruction;
        data_t pc_plus_4;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        data_t     ra_data;
        data_t     rb_data;
        data_t     immediate;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        data_t     alu_result;
        data_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        data_t     wb_data;
    } mem_wb_t;

endpackage

/* design/instruction_fetch.sv */
`timescale 1ns/1ps

module instruction_fetch #(
    parameter int NB_PROG_ADDRESS = 6
) (
    input  logic             i_clock,
    input  logic             i_rst,
    input  logic             i_run,
    input  logic             i_delete_program,
    input  logic             i_load_program_write_enable,
    input  logic [7:0]       i_load_program_byte,
    output mips_pkg::if_id_t o_if_id,
    output mips_pkg::data_t  o_pc,
    output logic             o_is_program_end
);
    import mips_pkg::*;

    localparam int N_PROG_WORDS = 2 ** NB_PROG_ADDRESS;

    data_t                      program_memory [N_PROG_WORDS];
    logic [NB_PROG_ADDRESS-1:0] load_address;
    logic [1:0]                 load_byte_index;
    logic [23:0]                load_partial_word;
    data_t                      fetched_instruction;
    logic                       fetched_halt;
    data_t                      pc_plus_4;

    // ------------------------------------------------------------------------
    // Program loader
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_rst || i_delete_program) begin
            load_address    <= '0;
            load_byte_index <= '0;
        end else if (i_load_program_write_enable) begin
            load_byte_index <= load_byte_index + 2'd1;
            if (load_byte_index == 2'd3) begin
                load_address <= load_address + 1'b1;
            end
        end
    end

    // Most significant byte arrives first
    always_ff @(posedge i_clock) begin
        if (i_load_program_write_enable) begin
            load_partial_word <= {load_partial_word[15:0], i_load_program_byte};
            if (load_byte_index == 2'd3) begin
                program_memory[load_address] <= {load_partial_word, i_load_program_byte};
            end
        end
    end

    // ------------------------------------------------------------------------
    // PC, halt detection and IF/ID
    // ------------------------------------------------------------------------
    assign fetched_instruction = program_memory[o_pc[NB_PROG_ADDRESS+1:2]];
    assign fetched_halt        = (fetched_instruction == INSTR_HALT);
    assign pc_plus_4           = o_pc + 32'd4;

    always_ff @(posedge i_clock) begin
        if (i_rst || i_delete_program) begin
            o_pc             <= '0;
            o_is_program_end <= 1'b0;
            o_if_id          <= '{instruction: INSTR_NOP, pc_plus_4: '0};
        end else if (i_run) begin
            if (o_is_program_end || fetched_halt) begin
                // PC parks on the HALT word, pipeline drains with NOPs
                o_is_program_end <= 1'b1;
                o_if_id          <= '{instruction: INSTR_NOP, pc_plus_4: '0};
            end else begin
                o_pc    <= pc_plus_4;
                o_if_id <= '{instruction: fetched_instruction, pc_plus_4: pc_plus_4};
            end
        end
    end

    pc_frozen_at_end : assert property (
        @(posedge i_clock)
        (o_is_program_end && !i_rst && !i_delete_program) |=> $stable(o_pc)
    );

endmodule

/* design/register_bank.sv */
`timescale 1ns/1ps

module register_bank (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_write_enable,
    input  mips_pkg::reg_addr_t i_write_address,
    input  mips_pkg::data_t     i_write_data,
    input  mips_pkg::reg_addr_t i_read_address_a,
    input  mips_pkg::reg_addr_t i_read_address_b,
    input  mips_pkg::reg_addr_t i_debug_read_address,
    output mips_pkg::data_t     o_read_data_a,
    output mips_pkg::data_t     o_read_data_b,
    output mips_pkg::data_t     o_debug_read_data
);
    import mips_pkg::*;

    localparam int N_REGISTERS = 2 ** NB_REG_ADDRESS;

    data_t registers [N_REGISTERS];
    logic  write_valid;

    // r0 is hardwired, so its writes are dropped here
    assign write_valid = i_write_enable && (i_write_address != '0);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < N_REGISTERS; i++) begin
                registers[i] <= '0;
            end
        end else if (write_valid) begin
            registers[i_write_address] <= i_write_data;
        end
    end

    // Write-first bypass covers the last cycle of the producer/consumer gap
    assign o_read_data_a = (write_valid && (i_read_address_a == i_write_address)) ?
                           i_write_data : registers[i_read_address_a];
    assign o_read_data_b = (write_valid && (i_read_address_b == i_write_address)) ?
                           i_write_data : registers[i_read_address_b];

    assign o_debug_read_data = registers[i_debug_read_address];

    // Both read ports see zero for r0, through the bypass or the storage
    r0_stays_zero : assert property (
        @(posedge i_clock) disable iff (i_rst)
        ((i_read_address_a != '0) || (o_read_data_a == '0)) &&
        ((i_read_address_b != '0) || (o_read_data_b == '0))
    );

endmodule

/* design/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_run,
    input  mips_pkg::if_id_t    i_if_id,
    input  mips_pkg::mem_wb_t   i_mem_wb,
    input  mips_pkg::reg_addr_t i_debug_read_reg_address,
    output mips_pkg::id_ex_t    o_id_ex,
    output mips_pkg::data_t     o_debug_read_reg
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    ctrl_t       ctrl;
    data_t       immediate;
    data_t       ra_data;
    data_t       rb_data;

    assign opcode = i_if_id.instruction[31:26];
    assign rs     = i_if_id.instruction[25:21];
    assign rt     = i_if_id.instruction[20:16];
    assign rd     = i_if_id.instruction[15:11];
    assign imm    = i_if_id.instruction[15:0];
    assign funct  = i_if_id.instruction[5:0];

    // ------------------------------------------------------------------------
    // Control decoding
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    // NOP falls in here with function 0
                    default: ctrl = '0;
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.zero_extend = 1'b1;
                ctrl.alu_op      = (opcode == OP_ANDI) ? ALU_AND :
                                   (opcode == OP_ORI)  ? ALU_OR  : ALU_LUI;
            end
            OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
            end
            // HALT and unknown opcodes
            default: ctrl = '0;
        endcase
    end

    assign immediate = ctrl.zero_extend ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    register_bank u_register_bank (
        .i_clock              (i_clock                 ),
        .i_rst                (i_rst                   ),
        .i_write_enable       (i_mem_wb.reg_write      ),
        .i_write_address      (i_mem_wb.dest           ),
        .i_write_data         (i_mem_wb.wb_data        ),
        .i_read_address_a     (rs                      ),
        .i_read_address_b     (rt                      ),
        .i_debug_read_address (i_debug_read_reg_address),
        .o_read_data_a        (ra_data                 ),
        .o_read_data_b        (rb_data                 ),
        .o_debug_read_data    (o_debug_read_reg        )
    );

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (i_run) begin
            o_id_ex <= '{ctrl: ctrl, ra_data: ra_data, rb_data: rb_data,
                         immediate: immediate, rt: rt, rd: rd};
        end
    end

endmodule

/* design/execution.sv */
`timescale 1ns/1ps

module execution (
    input  logic              i_clock,
    input  logic              i_rst,
    input  logic              i_run,
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);
    import mips_pkg::*;

    data_t     operand_a;
    data_t     operand_b;
    data_t     alu_result;
    reg_addr_t dest;

    assign operand_a = i_id_ex.ra_data;
    assign operand_b = i_id_ex.ctrl.alu_src_imm ? i_id_ex.immediate : i_id_ex.rb_data;

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = operand_a + operand_b;
            ALU_SUB: alu_result = operand_a - operand_b;
            ALU_AND: alu_result = operand_a & operand_b;
            ALU_OR:  alu_result = operand_a | operand_b;
            ALU_XOR: alu_result = operand_a ^ operand_b;
            ALU_SLT: alu_result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            ALU_LUI: alu_result = {i_id_ex.immediate[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    // rd for R-type, rt for immediates and loads
    assign dest = i_id_ex.ctrl.reg_dst_rd ? i_id_ex.rd : i_id_ex.rt;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else if (i_run) begin
            o_ex_mem <= '{
                reg_write:  i_id_ex.ctrl.reg_write,
                mem_to_reg: i_id_ex.ctrl.mem_to_reg,
                mem_write:  i_id_ex.ctrl.mem_write,
                alu_result: alu_result,
                store_data: i_id_ex.rb_data,
                dest:       dest
            };
        end
    end

endmodule

/* design/memory_access.sv */
`timescale 1ns/1ps

module memory_access #(
    parameter int NB_MEM_ADDRESS = 7
) (
    input  logic                      i_clock,
    input  logic                      i_rst,
    input  logic                      i_run,
    input  mips_pkg::ex_mem_t         i_ex_mem,
    input  logic [NB_MEM_ADDRESS-1:0] i_debug_read_mem_address,
    output mips_pkg::mem_wb_t         o_mem_wb,
    output mips_pkg::data_t           o_debug_read_mem
);
    import mips_pkg::*;

    localparam int N_MEM_WORDS = 2 ** NB_MEM_ADDRESS;

    data_t                     data_memory [N_MEM_WORDS];
    logic [NB_MEM_ADDRESS-1:0] word_address;
    data_t                     read_data;
    data_t                     wb_data;

    // Byte address from the ALU, low two bits dropped
    assign word_address = i_ex_mem.alu_result[NB_MEM_ADDRESS+1:2];
    assign read_data    = data_memory[word_address];

    always_ff @(posedge i_clock) begin
        if (i_run && i_ex_mem.mem_write) begin
            data_memory[word_address] <= i_ex_mem.store_data;
        end
    end

    assign wb_data = i_ex_mem.mem_to_reg ? read_data : i_ex_mem.alu_result;

    // ------------------------------------------------------------------------
    // MEM/WB
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_mem_wb <= '0;
        end else if (i_run) begin
            o_mem_wb <= '{
                reg_write: i_ex_mem.reg_write,
                dest:      i_ex_mem.dest,
                wb_data:   wb_data
            };
        end
    end

    assign o_debug_read_mem = data_memory[i_debug_read_mem_address];

    // Store address is computed in execution from a register plus offset
    store_in_range : assert property (
        @(posedge i_clock) disable iff (i_rst)
        (i_run && i_ex_mem.mem_write) |-> ((i_ex_mem.alu_result >> (NB_MEM_ADDRESS + 2)) == '0)
    );

endmodule

/* design/mips.sv */
`timescale 1ns/1ps

module mips #(
    parameter int NB_PROG_ADDRESS = 6,
    parameter int NB_MEM_ADDRESS  = 7
) (
    input  logic                      i_clock,
    input  logic                      i_rst,
    input  logic                      i_run,
    input  logic                      i_load_program_write_enable,
    input  logic [7:0]                i_load_program_byte,
    input  logic                      i_delete_program,
    input  mips_pkg::reg_addr_t       i_debug_read_reg_address,
    input  logic [NB_MEM_ADDRESS-1:0] i_debug_read_mem_address,
    output mips_pkg::data_t           o_debug_read_reg,
    output mips_pkg::data_t           o_debug_read_mem,
    output mips_pkg::data_t           o_debug_read_pc,
    output logic                      o_is_program_end
);
    import mips_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // ------------------------------------------------------------------------
    // Fetch and decode
    // ------------------------------------------------------------------------
    instruction_fetch #(
        .NB_PROG_ADDRESS (NB_PROG_ADDRESS)
    ) u_instruction_fetch (
        .i_clock                     (i_clock                    ),
        .i_rst                       (i_rst                      ),
        .i_run                       (i_run                      ),
        .i_delete_program            (i_delete_program           ),
        .i_load_program_write_enable (i_load_program_write_enable),
        .i_load_program_byte         (i_load_program_byte        ),
        .o_if_id                     (if_id                      ),
        .o_pc                        (o_debug_read_pc            ),
        .o_is_program_end            (o_is_program_end           )
    );

    // Write-back closes the loop into the register bank
    instruction_decode u_instruction_decode (
        .i_clock                  (i_clock                 ),
        .i_rst                    (i_rst                   ),
        .i_run                    (i_run                   ),
        .i_if_id                  (if_id                   ),
        .i_mem_wb                 (mem_wb                  ),
        .i_debug_read_reg_address (i_debug_read_reg_address),
        .o_id_ex                  (id_ex                   ),
        .o_debug_read_reg         (o_debug_read_reg        )
    );

    // ------------------------------------------------------------------------
    // Execution and memory access
    // ------------------------------------------------------------------------
    execution u_execution (
        .i_clock  (i_clock),
        .i_rst    (i_rst  ),
        .i_run    (i_run  ),
        .i_id_ex  (id_ex  ),
        .o_ex_mem (ex_mem )
    );

    memory_access #(
        .NB_MEM_ADDRESS (NB_MEM_ADDRESS)
    ) u_memory_access (
        .i_clock                  (i_clock                 ),
        .i_rst                    (i_rst                   ),
        .i_run                    (i_run                   ),
        .i_ex_mem                 (ex_mem                  ),
        .i_debug_read_mem_address (i_debug_read_mem_address),
        .o_mem_wb                 (mem_wb                  ),
        .o_debug_read_mem         (o_debug_read_mem        )
    );

endmodule

/* verification/mips_tb_programs.svh */
// ---------------------------------------------------------------------------
// Program table, one row per test
// ---------------------------------------------------------------------------
localparam int N_TESTS    = 6;
localparam int MAX_WORDS  = 24;
localparam int MAX_CHECKS = 8;

typedef enum {CHECK_REG, CHECK_MEM, CHECK_PC} check_kind_e;

string       test_name   [N_TESTS];
data_t       prog_words  [N_TESTS][MAX_WORDS];
int          prog_length [N_TESTS] = '{default: 0};
check_kind_e check_kind  [N_TESTS][MAX_CHECKS];
int          check_addr  [N_TESTS][MAX_CHECKS];
data_t       check_value [N_TESTS][MAX_CHECKS];
int          check_count [N_TESTS] = '{default: 0};

function automatic data_t rtype_word(input int rs, input int rt, input int rd,
                                     input logic [5:0] fn);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic data_t itype_word(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

task automatic add_word(input int t, input data_t word);
    prog_words[t][prog_length[t]] = word;
    prog_length[t]++;
endtask

task automatic add_nops(input int t, input int n);
    for (int i = 0; i < n; i++) begin
        add_word(t, INSTR_NOP);
    end
endtask

task automatic add_check(input int t, input check_kind_e kind, input int addr,
                         input data_t value);
    check_kind[t][check_count[t]]  = kind;
    check_addr[t][check_count[t]]  = addr;
    check_value[t][check_count[t]] = value;
    check_count[t]++;
endtask

// Producers and consumers sit at least three words apart
task automatic fill_table();
    data_t op_a;
    data_t op_b;
    op_a = $random(seed);
    op_b = $random(seed);

    test_name[0] = "load_and_end";
    add_nops(0, 5);
    add_word(0, INSTR_HALT);
    add_check(0, CHECK_PC, 0, 4 * 5);

    test_name[1] = "register_arith";
    add_word(1, itype_word(OP_ADDI, 0, 1, 16'd7));
    add_word(1, itype_word(OP_ADDI, 0, 2, -16'd3));
    add_word(1, itype_word(OP_ADDI, 0, 3, 16'd12));
    add_nops(1, 2);
    add_word(1, rtype_word(1, 3, 4, FN_ADDU));
    add_word(1, rtype_word(1, 3, 5, FN_SUBU));
    add_word(1, rtype_word(1, 3, 6, FN_AND));
    add_word(1, rtype_word(1, 3, 7, FN_OR));
    add_word(1, rtype_word(1, 3, 8, FN_XOR));
    add_word(1, rtype_word(2, 1, 9, FN_SLT));
    add_word(1, rtype_word(1, 2, 10, FN_SLT));
    add_word(1, INSTR_HALT);
    add_check(1, CHECK_REG, 4, 32'd7 + 32'd12);
    add_check(1, CHECK_REG, 5, 32'd7 - 32'd12);
    add_check(1, CHECK_REG, 6, 32'd7 & 32'd12);
    add_check(1, CHECK_REG, 7, 32'd7 | 32'd12);
    add_check(1, CHECK_REG, 8, 32'd7 ^ 32'd12);
    add_check(1, CHECK_REG, 9, 32'd1);
    add_check(1, CHECK_REG, 10, 32'd0);

    test_name[2] = "immediates";
    add_word(2, itype_word(OP_ADDI, 0, 11, -16'd100));
    add_word(2, itype_word(OP_ORI, 0, 12, 16'h8001));
    add_word(2, itype_word(OP_LUI, 0, 14, 16'h8123));
    add_word(2, itype_word(OP_ANDI, 11, 13, 16'hf0f0));
    add_word(2, INSTR_HALT);
    add_check(2, CHECK_REG, 11, -32'd100);
    add_check(2, CHECK_REG, 12, {16'h0000, 16'h8001});
    add_check(2, CHECK_REG, 13, -32'd100 & {16'h0000, 16'hf0f0});
    add_check(2, CHECK_REG, 14, {16'h8123, 16'h0000});

    test_name[3] = "memory";
    add_word(3, itype_word(OP_ADDI, 0, 1, 16'h1234));
    add_word(3, itype_word(OP_LUI, 0, 2, 16'hcafe));
    add_nops(3, 1);
    add_word(3, itype_word(OP_SW, 0, 1, 16'd8));
    add_word(3, itype_word(OP_SW, 0, 2, 16'd12));
    add_word(3, itype_word(OP_LW, 0, 15, 16'd8));
    add_word(3, itype_word(OP_LW, 0, 16, 16'd12));
    add_word(3, INSTR_HALT);
    add_check(3, CHECK_MEM, 8 / 4, 32'h0000_1234);
    add_check(3, CHECK_MEM, 12 / 4, {16'hcafe, 16'h0000});
    add_check(3, CHECK_REG, 15, 32'h0000_1234);
    add_check(3, CHECK_REG, 16, {16'hcafe, 16'h0000});

    test_name[4] = "r0_and_nop";
    add_word(4, itype_word(OP_ADDI, 0, 0, 16'd55));
    add_word(4, itype_word(OP_ADDI, 0, 17, 16'd21));
    add_nops(4, 6);
    add_word(4, INSTR_HALT);
    add_check(4, CHECK_REG, 0, 32'd0);
    add_check(4, CHECK_REG, 17, 32'd21);

    // Operands built in two halves
    test_name[5] = "random_reload";
    add_word(5, itype_word(OP_LUI, 0, 18, op_a[31:16]));
    add_word(5, itype_word(OP_LUI, 0, 19, op_b[31:16]));
    add_nops(5, 1);
    add_word(5, itype_word(OP_ORI, 18, 18, op_a[15:0]));
    add_word(5, itype_word(OP_ORI, 19, 19, op_b[15:0]));
    add_nops(5, 2);
    add_word(5, rtype_word(18, 19, 20, FN_ADDU));
    add_word(5, rtype_word(18, 19, 21, FN_XOR));
    add_word(5, INSTR_HALT);
    add_check(5, CHECK_REG, 18, op_a);
    add_check(5, CHECK_REG, 19, op_b);
    add_check(5, CHECK_REG, 20, op_a + op_b);
    add_check(5, CHECK_REG, 21, op_a ^ op_b);
endtask

/* verification/mips_tb.sv */
`timescale 1ns/1ps

module mips_tb;
    import mips_pkg::*;

    localparam int NB_PROG_ADDRESS = 6;
    localparam int NB_MEM_ADDRESS  = 7;
    localparam int END_TIMEOUT     = 200;

    logic                      i_clock;
    logic                      i_rst;
    logic                      i_run;
    logic                      i_load_program_write_enable;
    logic [7:0]                i_load_program_byte;
    logic                      i_delete_program;
    reg_addr_t                 i_debug_read_reg_address;
    logic [NB_MEM_ADDRESS-1:0] i_debug_read_mem_address;
    data_t                     o_debug_read_reg;
    data_t                     o_debug_read_mem;
    data_t                     o_debug_read_pc;
    logic                      o_is_program_end;

    int     errors       = 0;
    int     test_errors  = 0;
    int     passed_tests = 0;
    int     failed_tests = 0;
    bit     timed_out    = 1'b0;
    integer seed         = 30;

    `include "mips_tb_programs.svh"

    mips #(
        .NB_PROG_ADDRESS (NB_PROG_ADDRESS),
        .NB_MEM_ADDRESS  (NB_MEM_ADDRESS )
    ) mips_inst (
        .i_clock                     (i_clock                    ),
        .i_rst                       (i_rst                      ),
        .i_run                       (i_run                      ),
        .i_load_program_write_enable (i_load_program_write_enable),
        .i_load_program_byte         (i_load_program_byte        ),
        .i_delete_program            (i_delete_program           ),
        .i_debug_read_reg_address    (i_debug_read_reg_address   ),
        .i_debug_read_mem_address    (i_debug_read_mem_address   ),
        .o_debug_read_reg            (o_debug_read_reg           ),
        .o_debug_read_mem            (o_debug_read_mem           ),
        .o_debug_read_pc             (o_debug_read_pc            ),
        .o_is_program_end            (o_is_program_end           )
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    task automatic compare_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            test_errors++;
        end
    endtask

    // ---------------------------------------------------------------------------
    // Program handling
    // ---------------------------------------------------------------------------
    task automatic delete_program();
        @(negedge i_clock);
        i_delete_program = 1'b1;
        @(negedge i_clock);
        i_delete_program = 1'b0;
    endtask

    // Four bytes per word, MSB first
    task automatic load_program(input int t);
        for (int w = 0; w < prog_length[t]; w++) begin
            for (int b = 0; b < 4; b++) begin
                @(negedge i_clock);
                i_load_program_write_enable = 1'b1;
                i_load_program_byte         = prog_words[t][w][31 - 8 * b -: 8];
            end
        end
        @(negedge i_clock);
        i_load_program_write_enable = 1'b0;
    endtask

    task automatic wait_program_end(output bit reached);
        reached = 1'b0;
        for (int c = 0; c < END_TIMEOUT; c++) begin
            @(negedge i_clock);
            if (o_is_program_end) begin
                reached = 1'b1;
                break;
            end
        end
    endtask

    task automatic run_checks(input int t);
        string label;
        data_t actual;
        for (int k = 0; k < check_count[t]; k++) begin
            @(negedge i_clock);
            i_debug_read_reg_address = 5'(check_addr[t][k]);
            i_debug_read_mem_address = NB_MEM_ADDRESS'(check_addr[t][k]);
            #1;
            case (check_kind[t][k])
                CHECK_REG: begin
                    label  = $sformatf("%s r%0d", test_name[t], check_addr[t][k]);
                    actual = o_debug_read_reg;
                end
                CHECK_MEM: begin
                    label  = $sformatf("%s mem[%0d]", test_name[t], check_addr[t][k]);
                    actual = o_debug_read_mem;
                end
                default: begin
                    label  = $sformatf("%s pc", test_name[t]);
                    actual = o_debug_read_pc;
                end
            endcase
            compare_value(label, check_value[t][k], actual);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Test loop
    // ---------------------------------------------------------------------------
    initial begin
        bit reached;
        i_rst                       = 1'b1;
        i_run                       = 1'b0;
        i_load_program_write_enable = 1'b0;
        i_load_program_byte         = 8'h00;
        i_delete_program            = 1'b0;
        i_debug_read_reg_address    = '0;
        i_debug_read_mem_address    = '0;
        fill_table();
        repeat (2) @(negedge i_clock);
        i_rst = 1'b0;

        for (int t = 0; t < N_TESTS && !timed_out; t++) begin
            test_errors = 0;
            delete_program();
            compare_value({test_name[t], " end cleared"}, 32'd0, 32'(o_is_program_end));
            compare_value({test_name[t], " pc cleared"}, 32'd0, o_debug_read_pc);
            load_program(t);
            @(negedge i_clock);
            i_run = 1'b1;
            wait_program_end(reached);
            if (!reached) begin
                $display("%s: program never reached its end within %0d cycles",
                         test_name[t], END_TIMEOUT);
                timed_out = 1'b1;
                failed_tests++;
            end else begin
                // Drain the last instructions before HALT
                repeat (4) @(negedge i_clock);
                i_run = 1'b0;
                compare_value({test_name[t], " end"}, 32'd1, 32'(o_is_program_end));
                run_checks(t);
                if (test_errors == 0) begin
                    passed_tests++;
                    $display("%s: ok", test_name[t]);
                end else begin
                    failed_tests++;
                    $display("%s: %0d mismatches", test_name[t], test_errors);
                end
            end
            errors += test_errors;
        end

        $display("Summary: %0d passed, %0d failed", passed_tests, failed_tests);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+verification
design/mips_pkg.sv
design/instruction_fetch.sv
design/register_bank.sv
design/instruction_decode.sv
design/execution.sv
design/memory_access.sv
design/mips.sv
verification/mips_tb.sv
